//--- rtl/svm_pkg.sv
package svm_pkg;

    // datapath width for duty, period and threshold words
    localparam int unsigned d_width = 16;

    // wishbone word address width
    localparam int unsigned adr_width = 3;

    // register map
    localparam logic [adr_width-1:0] adr_va     = 3'd0;
    localparam logic [adr_width-1:0] adr_vb     = 3'd1;
    localparam logic [adr_width-1:0] adr_vc     = 3'd2;
    localparam logic [adr_width-1:0] adr_top    = 3'd3;
    localparam logic [adr_width-1:0] adr_ctrl   = 3'd4;
    localparam logic [adr_width-1:0] adr_status = 3'd5;

    // control register bits, load clears itself
    localparam int unsigned ctrl_run  = 0;
    localparam int unsigned ctrl_load = 1;

    // full-scale duty reference used by the threshold rule
    localparam logic [d_width-1:0] duty_full = 16'h7fff;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [adr_width-1:0] adr;
        logic [d_width-1:0]   dat;
    } wb_req_t;

    typedef struct packed {
        logic               ack;
        logic [d_width-1:0] dat;
    } wb_rsp_t;

    // duty words plus carrier half-period, decode to execute
    typedef struct packed {
        logic [d_width-1:0] va;
        logic [d_width-1:0] vb;
        logic [d_width-1:0] vc;
        logic [d_width-1:0] top;
    } duty_set_t;

    // compare thresholds plus half-period, execute to result
    typedef struct packed {
        logic [d_width-1:0] ta;
        logic [d_width-1:0] tb;
        logic [d_width-1:0] tc;
        logic [d_width-1:0] top;
    } thr_set_t;

endpackage

//--- rtl/svm_regs.sv
module svm_regs (
    input  logic               clk,
    input  logic               rstb,
    input  svm_pkg::wb_req_t   wb_in,
    output svm_pkg::wb_rsp_t   wb_out,
    output svm_pkg::duty_set_t duty,
    output logic               load_req,
    input  logic               exec_idle,
    input  logic               running,
    output logic               run
);
    import svm_pkg::*;

    duty_set_t          duty_q;
    logic               run_q;
    logic               load_pending;
    logic               ack_q;
    logic [d_width-1:0] rdat_q;
    logic [d_width-1:0] rdat_mux;
    logic [d_width-1:0] ctrl_word;
    logic [d_width-1:0] status_word;
    logic               active;
    logic               accept;
    logic               busy;

    // classic cycle, one ack per request
    assign active = wb_in.cyc & wb_in.stb;
    assign accept = active & ~ack_q;

    // busy covers the whole load path, not just the sequencer
    assign busy = ~exec_idle | load_pending | load_req;

    always_comb begin
        ctrl_word = '0;
        ctrl_word[ctrl_run] = run_q;
    end

    always_comb begin
        status_word = '0;
        status_word[0] = busy;
        status_word[1] = running;
    end

    // read mux, unmapped addresses give 0
    always_comb begin
        case (wb_in.adr)
            adr_va:     rdat_mux = duty_q.va;
            adr_vb:     rdat_mux = duty_q.vb;
            adr_vc:     rdat_mux = duty_q.vc;
            adr_top:    rdat_mux = duty_q.top;
            adr_ctrl:   rdat_mux = ctrl_word;
            adr_status: rdat_mux = status_word;
            default:    rdat_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstb) begin
            ack_q        <= 1'b0;
            duty_q       <= '0;
            run_q        <= 1'b0;
            load_pending <= 1'b0;
            load_req     <= 1'b0;
        end else begin
            ack_q <= accept;

            // hold the load until the execute stage can take it
            load_req <= load_pending & exec_idle;
            if (load_pending && exec_idle) begin
                load_pending <= 1'b0;
            end

            if (accept && wb_in.we) begin
                case (wb_in.adr)
                    adr_va:  duty_q.va  <= wb_in.dat;
                    adr_vb:  duty_q.vb  <= wb_in.dat;
                    adr_vc:  duty_q.vc  <= wb_in.dat;
                    adr_top: duty_q.top <= wb_in.dat;
                    adr_ctrl: begin
                        run_q <= wb_in.dat[ctrl_run];
                        if (wb_in.dat[ctrl_load]) begin
                            load_pending <= 1'b1;
                        end
                    end
                    default: begin
                        // status and unmapped words are read only
                    end
                endcase
            end
        end
    end

    // read data is sampled on the same edge that raises ack
    always_ff @(posedge clk) begin
        if (accept) begin
            rdat_q <= rdat_mux;
        end
    end

    assign wb_out = '{ack: ack_q, dat: rdat_q};
    assign duty   = duty_q;
    assign run    = run_q;

    // the master must see a gap between two acks
    ack_single: assert property (@(posedge clk) disable iff (!rstb)
        wb_out.ack |=> !wb_out.ack)
        else $error("ack held for two cycles");

endmodule

//--- rtl/duty_to_compare.sv
module duty_to_compare (
    input  logic               clk,
    input  logic               rstb,
    input  svm_pkg::duty_set_t duty,
    input  logic               load_req,
    output logic               idle,
    output svm_pkg::thr_set_t  thr,
    output logic               thr_valid,
    input  logic               thr_ready
);
    import svm_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_ph_a,
        st_ph_b,
        st_ph_c,
        st_offer
    } state_t;

    state_t               state;
    duty_set_t            duty_q;
    thr_set_t             thr_q;
    logic [d_width-1:0]   v_sel;
    logic [d_width-1:0]   diff;
    logic [2*d_width-1:0] prod;
    logic [d_width-1:0]   t_new;

    // one phase per cycle through the shared multiplier
    always_comb begin
        case (state)
            st_ph_a: v_sel = duty_q.va;
            st_ph_b: v_sel = duty_q.vb;
            st_ph_c: v_sel = duty_q.vc;
            default: v_sel = duty_full;
        endcase
    end

    // t = top * (full - v), upper half kept as the threshold
    assign diff  = duty_full - v_sel;
    assign prod  = duty_q.top * diff;
    assign t_new = prod[2*d_width-1:d_width];

    always_ff @(posedge clk) begin
        if (!rstb) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:  if (load_req) state <= st_ph_a;
                st_ph_a:  state <= st_ph_b;
                st_ph_b:  state <= st_ph_c;
                st_ph_c:  state <= st_offer;
                st_offer: if (thr_ready) state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && load_req) begin
            duty_q <= duty;
        end
        case (state)
            st_ph_a: begin
                thr_q.ta  <= t_new;
                thr_q.top <= duty_q.top;
            end
            st_ph_b: thr_q.tb <= t_new;
            st_ph_c: thr_q.tc <= t_new;
            default: begin
            end
        endcase
    end

    assign idle      = (state == st_idle);
    assign thr_valid = (state == st_offer);
    assign thr       = thr_q;

    // the carrier may hold off the set for a whole period
    thr_hold: assert property (@(posedge clk) disable iff (!rstb)
        thr_valid && !thr_ready |=> thr_valid && $stable(thr))
        else $error("threshold set changed before transfer");

endmodule

//--- rtl/carrier_pwm.sv
module carrier_pwm (
    input  logic              clk,
    input  logic              rstb,
    input  svm_pkg::thr_set_t thr,
    input  logic              thr_valid,
    output logic              thr_ready,
    input  logic              run,
    output logic              running,
    output logic              pwm_a,
    output logic              pwm_b,
    output logic              pwm_c,
    output logic              halt
);
    import svm_pkg::*;

    thr_set_t           act;
    logic [d_width-1:0] counter;
    logic [d_width-1:0] counter_nxt;
    logic               rising;
    logic               turn;
    logic               last;
    logic               armed;
    logic               take;

    // turn around at top on the way up and always step down when falling
    assign turn        = ~rising | (counter >= act.top);
    assign counter_nxt = turn ? counter - 1'b1 : counter + 1'b1;

    // final cycle of a period where the next count would be 0
    assign last = running & turn & (counter <= d_width'(1));

    // new sets only when idle or at the period boundary
    assign thr_ready = ~running | (run & last);
    assign take      = thr_valid & thr_ready;

    always_ff @(posedge clk) begin
        if (!rstb) begin
            counter <= '0;
            rising  <= 1'b1;
            running <= 1'b0;
            armed   <= 1'b0;
        end else if (!running) begin
            counter <= '0;
            rising  <= 1'b1;
            // start needs run plus a set loaded since the last stop
            if (run && (armed || thr_valid)) begin
                running <= 1'b1;
                armed   <= 1'b0;
            end else if (thr_valid) begin
                armed <= 1'b1;
            end
        end else if (last) begin
            counter <= '0;
            rising  <= 1'b1;
            if (!run) begin
                running <= 1'b0;
            end
        end else begin
            counter <= counter_nxt;
            rising  <= rising & ~turn;
        end
    end

    // active threshold set
    always_ff @(posedge clk) begin
        if (take) begin
            act <= thr;
        end
    end

    // center-aligned compare on the triangle carrier
    assign pwm_a = running & (counter >= act.ta);
    assign pwm_b = running & (counter >= act.tb);
    assign pwm_c = running & (counter >= act.tc);

    assign halt = (counter == '0);

    // a smaller top may only arrive while the count is at 0
    cnt_range: assert property (@(posedge clk) disable iff (!rstb)
        running |-> counter <= act.top)
        else $error("carrier count above active top");

endmodule

//--- rtl/svm_top.sv
module svm_top (
    input  logic             clk,
    input  logic             rstb,
    input  svm_pkg::wb_req_t wb_in,
    output svm_pkg::wb_rsp_t wb_out,
    output logic             pwm_a,
    output logic             pwm_b,
    output logic             pwm_c,
    output logic             halt
);
    import svm_pkg::*;

    // decode to execute
    duty_set_t duty;
    logic      load_req;
    logic      exec_idle;

    // execute to result
    thr_set_t  thr;
    logic      thr_valid;
    logic      thr_ready;

    // run control and status
    logic      run;
    logic      running;

    svm_regs u_regs (
        .clk       (clk),
        .rstb      (rstb),
        .wb_in     (wb_in),
        .wb_out    (wb_out),
        .duty      (duty),
        .load_req  (load_req),
        .exec_idle (exec_idle),
        .running   (running),
        .run       (run)
    );

    duty_to_compare u_exec (
        .clk       (clk),
        .rstb      (rstb),
        .duty      (duty),
        .load_req  (load_req),
        .idle      (exec_idle),
        .thr       (thr),
        .thr_valid (thr_valid),
        .thr_ready (thr_ready)
    );

    carrier_pwm u_pwm (
        .clk       (clk),
        .rstb      (rstb),
        .thr       (thr),
        .thr_valid (thr_valid),
        .thr_ready (thr_ready),
        .run       (run),
        .running   (running),
        .pwm_a     (pwm_a),
        .pwm_b     (pwm_b),
        .pwm_c     (pwm_c),
        .halt      (halt)
    );

endmodule

//--- testbench/svm_checker.sv
module svm_checker (
    input logic clk,
    input logic rstb,
    input logic xfer,
    input logic halt,
    input logic pwm_a,
    input logic pwm_b,
    input logic pwm_c
);
    timeunit 1ns;
    timeprecision 1ps;
    import svm_pkg::*;

    int val_errs = 0;
    int other_errs = 0;
    int windows = 0;
    int act_row = 0;
    int body_row = 0;
    int cnt_a = 0;
    int cnt_b = 0;
    int cnt_c = 0;
    logic win_open = 1'b0;
    logic halt_q = 1'b1;

    task automatic compare(input string name, input int exp, input int got);
        if (exp != got) begin
            $display("ERR time=%0t %s expected=%0d actual=%0d", $time, name, exp, got);
            val_errs++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("%0t: %s", $time, what);
        other_errs++;
    endtask

    function automatic int duty_of(input int r, input int ph);
        case (ph)
            0: return int'(svm_tb.tab[r].va);
            1: return int'(svm_tb.tab[r].vb);
            default: return int'(svm_tb.tab[r].vc);
        endcase
    endfunction

    // t = top * (full - v) >> 16, the difference wraps at 16 bits
    function automatic int threshold(input int v, input int top);
        logic [15:0] diff;
        longint      prod;
        diff = 16'(int'(duty_full) - v);
        prod = longint'(top) * longint'(diff);
        return int'(prod >> 16);
    endfunction

    function automatic int pulse(input int t, input int top);
        return (t == 0) ? 2 * top : 2 * (top - t) + 1;
    endfunction

    // a window runs from one step 0 to 1 up to the next, so its closing
    // zero cycle may already run on the following set
    function automatic int window_expect(input int ph, input int rb, input int rz);
        int top_b;
        int t_b;
        int t_z;
        top_b = int'(svm_tb.tab[rb].top);
        t_b   = threshold(duty_of(rb, ph), top_b);
        t_z   = threshold(duty_of(rz, ph), int'(svm_tb.tab[rz].top));
        return pulse(t_b, top_b) - int'(t_b == 0) + int'(t_z == 0);
    endfunction

    always @(negedge clk) begin
        if (!rstb) begin
            halt_q   = 1'b1;
            win_open = 1'b0;
        end else begin
            if (svm_tb.expect_idle && (!halt || pwm_a || pwm_b || pwm_c)) begin
                note_failure("carrier output active while the carrier should be stopped");
            end
            if (halt_q && !halt) begin
                if (win_open) begin
                    compare("pwm_a", window_expect(0, body_row, act_row), cnt_a);
                    compare("pwm_b", window_expect(1, body_row, act_row), cnt_b);
                    compare("pwm_c", window_expect(2, body_row, act_row), cnt_c);
                    windows++;
                end
                win_open = 1'b1;
                body_row = act_row;
                cnt_a    = 0;
                cnt_b    = 0;
                cnt_c    = 0;
            end
            if (win_open) begin
                cnt_a += int'(pwm_a);
                cnt_b += int'(pwm_b);
                cnt_c += int'(pwm_c);
            end
            halt_q = halt;
            // handed-over set is live from the next cycle
            if (xfer) begin
                act_row = svm_tb.row;
            end
        end
    end

endmodule

//--- testbench/svm_tb.sv
module svm_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import svm_pkg::*;

    localparam int n_rows = 14;

    typedef struct packed {
        logic [15:0] va;
        logic [15:0] vb;
        logic [15:0] vc;
        logic [15:0] top;
        logic        run;
        logic [7:0]  periods;
    } row_t;

    logic        clk;
    logic        rstb;
    wb_req_t     wb_in;
    wb_rsp_t     wb_out;
    logic        pwm_a;
    logic        pwm_b;
    logic        pwm_c;
    logic        halt;
    logic        xfer;
    logic        expect_idle = 1'b1;
    row_t        tab [n_rows];
    int          row = 0;
    int          seed;
    int          limit = 200;
    int          cycles = 0;
    logic [15:0] rd;
    logic [15:0] ctrl;

    svm_top u_svm_top (
        .clk    (clk),
        .rstb   (rstb),
        .wb_in  (wb_in),
        .wb_out (wb_out),
        .pwm_a  (pwm_a),
        .pwm_b  (pwm_b),
        .pwm_c  (pwm_c),
        .halt   (halt)
    );

    // execute to carrier hand-off, tells the checker when a row goes live
    assign xfer = u_svm_top.thr_valid & u_svm_top.thr_ready;

    svm_checker u_checker (
        .clk   (clk),
        .rstb  (rstb),
        .xfer  (xfer),
        .halt  (halt),
        .pwm_a (pwm_a),
        .pwm_b (pwm_b),
        .pwm_c (pwm_c)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic wb_write(input logic [adr_width-1:0] adr, input logic [15:0] dat);
        @(negedge clk);
        wb_in = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
        do @(negedge clk); while (!wb_out.ack);
        wb_in = '0;
    endtask

    task automatic wb_read(input logic [adr_width-1:0] adr, output logic [15:0] dat);
        @(negedge clk);
        wb_in = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 16'h0000};
        do @(negedge clk); while (!wb_out.ack);
        dat   = wb_out.dat;
        wb_in = '0;
    endtask

    // each period starts where halt falls
    task automatic wait_periods(input int n);
        repeat (n) begin
            do @(negedge clk); while (!halt);
            do @(negedge clk); while (halt);
        end
    endtask

    task automatic finish_run();
        int total;
        total = u_checker.val_errs + u_checker.other_errs;
        $display("errors: %0d (values %0d, other %0d), windows checked: %0d",
                 total, u_checker.val_errs, u_checker.other_errs, u_checker.windows);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    initial begin
        @(posedge rstb);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        u_checker.note_failure("timeout: the run did not finish within the cycle limit");
        finish_run();
    end

    initial begin
        rstb  = 1'b0;
        wb_in = '0;
        seed  = 61732;
        // full scale, zero duty, unequal phases, a stop, then a restart
        tab[0] = '{16'h7fff, 16'h0000, 16'h4000, 16'd40, 1'b1, 8'd3};
        tab[1] = '{16'h1000, 16'h3000, 16'h6000, 16'd64, 1'b1, 8'd2};
        tab[2] = '{16'h0000, 16'h0000, 16'h0000, 16'd64, 1'b0, 8'd2};
        tab[3] = '{16'h2000, 16'h7fff, 16'h0100, 16'd25, 1'b1, 8'd2};
        for (int i = 4; i < n_rows; i++) begin
            tab[i].va      = 16'($random(seed));
            tab[i].vb      = 16'($random(seed));
            tab[i].vc      = 16'($random(seed));
            tab[i].top     = 16'(16 + ($unsigned($random(seed)) % 185));
            tab[i].run     = 1'b1;
            tab[i].periods = 8'd2;
        end
        for (int i = 0; i < n_rows; i++) begin
            limit += 2 * int'(tab[i].top) * (int'(tab[i].periods) + 1);
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstb = 1'b1;

        for (int a = 0; a < 8; a++) begin
            wb_read(3'(a), rd);
            u_checker.compare($sformatf("wb_out.dat adr %0d", a), 0, int'(rd));
        end
        for (int a = 0; a < 4; a++) begin
            wb_write(3'(a), 16'ha5c3 ^ 16'(a * 16'h1111));
            wb_read(3'(a), rd);
            u_checker.compare($sformatf("wb_out.dat adr %0d", a),
                              int'(16'ha5c3 ^ 16'(a * 16'h1111)), int'(rd));
        end
        wb_write(3'd6, 16'hffff);
        wb_read(3'd6, rd);
        u_checker.compare("wb_out.dat adr 6", 0, int'(rd));
        wb_read(3'd7, rd);
        u_checker.compare("wb_out.dat adr 7", 0, int'(rd));

        // rows after the first are loaded early in a running period
        for (int i = 0; i < n_rows; i++) begin
            row = i;
            if (tab[i].run) begin
                wb_write(adr_va, tab[i].va);
                wb_write(adr_vb, tab[i].vb);
                wb_write(adr_vc, tab[i].vc);
                wb_write(adr_top, tab[i].top);
                ctrl = '0;
                ctrl[ctrl_run]  = 1'b1;
                ctrl[ctrl_load] = 1'b1;
                expect_idle = 1'b0;
                wb_write(adr_ctrl, ctrl);
                do wb_read(adr_status, rd); while (rd[0]);
                u_checker.compare("status.running", 1, int'(rd[1]));
                wait_periods(int'(tab[i].periods));
            end else begin
                wb_write(adr_ctrl, 16'h0000);
                do wb_read(adr_status, rd); while (rd[1]);
                u_checker.compare("status", 0, int'(rd));
                expect_idle = 1'b1;
                repeat (2 * int'(tab[i].top) * int'(tab[i].periods)) @(negedge clk);
            end
        end
        if (u_checker.windows == 0) begin
            u_checker.note_failure("no PWM period was observed");
        end
        finish_run();
    end

endmodule

//--- tb.f
rtl/svm_pkg.sv
rtl/svm_regs.sv
rtl/duty_to_compare.sv
rtl/carrier_pwm.sv
rtl/svm_top.sv
testbench/svm_checker.sv
testbench/svm_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP      = svm_tb
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check the log for the pass line"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "Test OK" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
